/* dv/tb.sv */
`timescale 1ns/1ps

module tb;
    import smartnic_pkg::*;

    // ========================================
    // Run parameters
    // ========================================

    localparam int MAX_BEATS         = 8;
    localparam int RR_PKTS_PER_SRC   = 4;
    localparam int RAND_PKTS_PER_SRC = 100;
    localparam int TOTAL_PKTS        = RAND_PKTS_PER_SRC * NUM_PORTS;
    // Four cycles per beat covers contention and stalls
    localparam int TIMEOUT_CYCLES    = TOTAL_PKTS * MAX_BEATS * 4 + 1000;
    localparam int READY_DROP_PCT    = 30;
    localparam int IDLE_PCT          = 15;
    localparam int NUM_PAIRS         = NUM_PORTS * NUM_PORTS;

    logic   axis_clk;
    logic   rst;
    logic   in_tvalid  [NUM_PORTS];
    logic   in_tready  [NUM_PORTS];
    tdata_t in_tdata   [NUM_PORTS];
    tkeep_t in_tkeep   [NUM_PORTS];
    logic   in_tlast   [NUM_PORTS];
    port_t  in_tdest   [NUM_PORTS];
    logic   out_tvalid [NUM_PORTS];
    logic   out_tready [NUM_PORTS];
    tdata_t out_tdata  [NUM_PORTS];
    tkeep_t out_tkeep  [NUM_PORTS];
    logic   out_tlast  [NUM_PORTS];
    port_t  out_tid    [NUM_PORTS];
    port_t  out_tdest  [NUM_PORTS];

    // Source generators
    int     pkts_left  [NUM_PORTS];
    int     beats_left [NUM_PORTS];
    port_t  cur_dest   [NUM_PORTS];
    logic   directed;
    logic   hold_ready;

    // Scoreboard, one queue per source and egress pair
    tdata_t exp_data [NUM_PAIRS][$];
    tkeep_t exp_keep [NUM_PAIRS][$];
    logic   exp_last [NUM_PAIRS][$];
    logic   pkt_open [NUM_PORTS];
    port_t  pkt_src  [NUM_PORTS];
    port_t  rr_order [$];

    int     sent_beats;
    int     recv_beats;
    int     err_count;
    int     tests_failed;
    int     cycle_count;

    smartnic_switch #(
        .NUM_PORTS (NUM_PORTS)
    ) u_smartnic_switch (
        .axis_clk   (axis_clk),
        .rst        (rst),
        .in_tvalid  (in_tvalid),
        .in_tready  (in_tready),
        .in_tdata   (in_tdata),
        .in_tkeep   (in_tkeep),
        .in_tlast   (in_tlast),
        .in_tdest   (in_tdest),
        .out_tvalid (out_tvalid),
        .out_tready (out_tready),
        .out_tdata  (out_tdata),
        .out_tkeep  (out_tkeep),
        .out_tlast  (out_tlast),
        .out_tid    (out_tid),
        .out_tdest  (out_tdest)
    );

    initial axis_clk = 1'b0;
    always #4 axis_clk = ~axis_clk;

    // ========================================
    // Compare tasks
    // ========================================

    task automatic check_data(input int e, input tdata_t got_data, input tdata_t want_data,
                              input tkeep_t got_keep, input tkeep_t want_keep,
                              input logic got_last, input logic want_last);
        if (got_data !== want_data || got_keep !== want_keep || got_last !== want_last) begin
            $display("CHECK FAILED t=%0t: egress %0d beat %h/%h/%b, expected %h/%h/%b",
                     $time, e, got_data, got_keep, got_last, want_data, want_keep, want_last);
            err_count++;
        end
    endtask

    task automatic check_port(input int e, input string what, input port_t got,
                              input port_t want);
        if (got !== want) begin
            $display("CHECK FAILED t=%0t: egress %0d %s is %0d, expected %0d",
                     $time, e, what, got, want);
            err_count++;
        end
    endtask

    task automatic check_reset_state(input port_t p, input logic got_tvalid,
                                     input logic got_tready);
        if (got_tvalid !== 1'b0 || got_tready !== 1'b1) begin
            $display("CHECK FAILED t=%0t: port %0d out_tvalid %b in_tready %b after reset",
                     $time, p, got_tvalid, got_tready);
            err_count++;
        end
    endtask

    // ========================================
    // Stimulus and model
    // ========================================

    function automatic int pair_index(input int src, input int dst);
        return src * NUM_PORTS + dst;
    endfunction

    task automatic record_ingress(input int s);
        int k;
        k = pair_index(s, int'(in_tdest[s]));
        exp_data[k].push_back(in_tdata[s]);
        exp_keep[k].push_back(in_tkeep[s]);
        exp_last[k].push_back(in_tlast[s]);
        sent_beats++;
    endtask

    task automatic drive_next_beat(input int s);
        if (beats_left[s] == 0) begin
            pkts_left[s]--;
            if (directed) begin
                beats_left[s] = 1;
                cur_dest[s]   = '0;
            end else begin
                beats_left[s] = int'($urandom_range(MAX_BEATS, 1));
                cur_dest[s]   = port_t'($urandom_range(NUM_PORTS - 1));
            end
        end
        beats_left[s]--;
        in_tvalid[s] <= 1'b1;
        in_tdata[s]  <= {$urandom, $urandom};
        in_tlast[s]  <= (beats_left[s] == 0);
        in_tdest[s]  <= cur_dest[s];
        if (beats_left[s] == 0) begin
            in_tkeep[s] <= tkeep_t'({KEEP_WID{1'b1}} >> $urandom_range(KEEP_WID - 1));
        end else begin
            in_tkeep[s] <= '1;
        end
    endtask

    // Sources and egress back-pressure share one process
    always @(posedge axis_clk) begin
        for (int e = 0; e < NUM_PORTS; e++) begin
            if (hold_ready) begin
                out_tready[e] <= 1'b1;
            end else begin
                out_tready[e] <= (int'($urandom_range(99)) >= READY_DROP_PCT);
            end
        end
        if (!rst) begin
            for (int s = 0; s < NUM_PORTS; s++) begin
                if (in_tvalid[s] && in_tready[s]) begin
                    record_ingress(s);
                    in_tvalid[s] <= 1'b0;
                end
                if ((!in_tvalid[s] || in_tready[s]) && (beats_left[s] > 0 || pkts_left[s] > 0)) begin
                    if (directed || int'($urandom_range(99)) >= IDLE_PCT) begin
                        drive_next_beat(s);
                    end
                end
            end
        end
    end

    task automatic check_egress_beat(input int e);
        int     k;
        port_t  src;
        tdata_t want_data;
        tkeep_t want_keep;
        logic   want_last;
        src = out_tid[e];
        check_port(e, "tdest", out_tdest[e], port_t'(e));
        // Same source until tlast
        if (pkt_open[e]) begin
            check_port(e, "tid inside packet", src, pkt_src[e]);
        end
        k = pair_index(int'(src), e);
        if (exp_data[k].size() == 0) begin
            $display("ERROR: t=%0t egress %0d got a beat from source %0d that nobody sent",
                     $time, e, src);
            err_count++;
        end else begin
            want_data = exp_data[k].pop_front();
            want_keep = exp_keep[k].pop_front();
            want_last = exp_last[k].pop_front();
            check_data(e, out_tdata[e], want_data, out_tkeep[e], want_keep,
                       out_tlast[e], want_last);
        end
        pkt_open[e] = !out_tlast[e];
        pkt_src[e]  = src;
        recv_beats++;
        if (directed && e == 0 && out_tlast[e]) begin
            rr_order.push_back(src);
        end
    endtask

    always @(posedge axis_clk) begin
        if (!rst) begin
            for (int e = 0; e < NUM_PORTS; e++) begin
                if (out_tvalid[e] && out_tready[e]) begin
                    check_egress_beat(e);
                end
            end
        end
    end

    always @(posedge axis_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: run timed out after %0d cycles with %0d of %0d beats received",
                     cycle_count, recv_beats, sent_beats);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ========================================
    // Test sequence
    // ========================================

    function automatic logic traffic_done();
        for (int s = 0; s < NUM_PORTS; s++) begin
            if (pkts_left[s] > 0 || beats_left[s] > 0 || in_tvalid[s]) begin
                return 1'b0;
            end
        end
        return recv_beats == sent_beats;
    endfunction

    task automatic wait_drained();
        while (!traffic_done()) begin
            @(negedge axis_clk);
        end
    endtask

    task automatic report_test(input string name, input int errs_at_start);
        if (err_count == errs_at_start) begin
            $display("TEST %s: pass", name);
        end else begin
            $display("TEST %s: fail with %0d errors", name, err_count - errs_at_start);
            tests_failed++;
        end
    endtask

    task automatic check_rotation();
        req_t seen;
        if (rr_order.size() != NUM_PORTS * RR_PKTS_PER_SRC) begin
            $display("ERROR: egress 0 carried %0d directed packets instead of %0d",
                     rr_order.size(), NUM_PORTS * RR_PKTS_PER_SRC);
            err_count++;
        end else begin
            // Every group of four must hold each source once
            for (int g = 0; g < RR_PKTS_PER_SRC; g++) begin
                seen = '0;
                for (int i = 0; i < NUM_PORTS; i++) begin
                    seen[rr_order[g * NUM_PORTS + i]] = 1'b1;
                end
                if (seen != '1) begin
                    $display("CHECK FAILED t=%0t: round %0d served sources %b", $time, g, seen);
                    err_count++;
                end
            end
        end
    endtask

    task automatic check_queues_empty();
        for (int k = 0; k < NUM_PAIRS; k++) begin
            if (exp_data[k].size() != 0) begin
                $display("ERROR: %0d beats from source %0d to egress %0d never arrived",
                         exp_data[k].size(), k / NUM_PORTS, k % NUM_PORTS);
                err_count++;
            end
        end
        for (int e = 0; e < NUM_PORTS; e++) begin
            if (pkt_open[e]) begin
                $display("ERROR: egress %0d ended with a packet still open", e);
                err_count++;
            end
        end
    endtask

    initial begin
        int errs_at_start;
        void'($urandom(32'h38709301));
        rst <= 1'b1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            in_tvalid[p]  <= 1'b0;
            in_tdata[p]   <= '0;
            in_tkeep[p]   <= '0;
            in_tlast[p]   <= 1'b0;
            in_tdest[p]   <= '0;
            out_tready[p] <= 1'b1;
            pkts_left[p]  = 0;
            beats_left[p] = 0;
            cur_dest[p]   = '0;
            pkt_open[p]   = 1'b0;
            pkt_src[p]    = '0;
        end
        directed     = 1'b0;
        hold_ready   = 1'b1;
        sent_beats   = 0;
        recv_beats   = 0;
        err_count    = 0;
        tests_failed = 0;
        cycle_count  = 0;

        errs_at_start = err_count;
        for (int i = 0; i < 10; i++) begin
            @(posedge axis_clk);
            if (i == 9) begin
                rst <= 1'b0;
            end
            @(negedge axis_clk);
            for (int p = 0; p < NUM_PORTS; p++) begin
                check_reset_state(port_t'(p), out_tvalid[p], in_tready[p]);
            end
        end
        // First cycle out of reset, nothing offered yet
        @(negedge axis_clk);
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_reset_state(port_t'(p), out_tvalid[p], in_tready[p]);
        end
        report_test("reset_state", errs_at_start);

        errs_at_start = err_count;
        directed = 1'b1;
        for (int s = 0; s < NUM_PORTS; s++) begin
            pkts_left[s] = RR_PKTS_PER_SRC;
        end
        wait_drained();
        check_rotation();
        report_test("round_robin", errs_at_start);

        errs_at_start = err_count;
        directed   = 1'b0;
        hold_ready = 1'b0;
        for (int s = 0; s < NUM_PORTS; s++) begin
            pkts_left[s] = RAND_PKTS_PER_SRC;
        end
        wait_drained();
        check_queues_empty();
        report_test("random_traffic", errs_at_start);

        $display("Summary: 3 tests, %0d failed, %0d errors, %0d beats sent, %0d received",
                 tests_failed, err_count, sent_beats, recv_beats);
        if (err_count == 0 && tests_failed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule : tb

/* filelist.f */
logic/smartnic_pkg.sv
logic/ingress_port.sv
logic/egress_arbiter.sv
logic/smartnic_switch.sv
dv/tb.sv

/* logic/egress_arbiter.sv */
`timescale 1ns/1ps

module egress_arbiter #(
    parameter int NUM_SRC = smartnic_pkg::NUM_PORTS
) (
    input  logic                 axis_clk,
    input  logic                 rst,

    // Per-source requests and head beats
    input  logic                 req       [NUM_SRC],
    input  smartnic_pkg::tdata_t src_tdata [NUM_SRC],
    input  smartnic_pkg::tkeep_t src_tkeep [NUM_SRC],
    input  logic                 src_tlast [NUM_SRC],
    output logic                 pop       [NUM_SRC],

    // Egress AXI-Stream
    output logic                 m_tvalid,
    input  logic                 m_tready,
    output smartnic_pkg::tdata_t m_tdata,
    output smartnic_pkg::tkeep_t m_tkeep,
    output logic                 m_tlast,
    output smartnic_pkg::port_t  m_tid
);
    import smartnic_pkg::*;

    // ========================================
    // Signals
    // ========================================

    arb_state_e state;

    // Current grantee, also the starting point for the next search
    port_t      winner;

    port_t      pick;
    logic       any_req;
    req_t       grant;

    logic       out_free;
    logic       pop_any;
    logic       pop_tlast;

    // ========================================
    // Round-robin search
    // ========================================

    // First requester after the previous winner
    always_comb begin
        int idx;
        pick    = winner;
        any_req = 1'b0;
        for (int k = 1; k <= NUM_SRC; k++) begin
            idx = (int'(winner) + k) % NUM_SRC;
            if (!any_req && req[idx]) begin
                any_req = 1'b1;
                pick    = port_t'(idx);
            end
        end
    end

    // ========================================
    // Packet lock FSM
    // ========================================

    always_ff @(posedge axis_clk) begin
        if (rst) begin
            state  <= ARB_IDLE;
            // Source 0 wins first after reset
            winner <= port_t'(NUM_SRC - 1);
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (any_req) begin
                        state  <= ARB_LOCKED;
                        winner <= pick;
                    end
                end
                ARB_LOCKED: begin
                    // Release once the last beat leaves the source
                    if (pop_any && pop_tlast) begin
                        state <= ARB_IDLE;
                    end
                end
                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

    // One-hot grant while locked
    always_comb begin
        grant = '0;
        for (int i = 0; i < NUM_SRC; i++) begin
            grant[i] = (state == ARB_LOCKED) && (winner == port_t'(i));
        end
    end

    // ========================================
    // Pop and output register
    // ========================================

    // Output slot empty or draining this cycle
    assign out_free = !m_tvalid || m_tready;

    always_comb begin
        pop_any = 1'b0;
        for (int i = 0; i < NUM_SRC; i++) begin
            pop[i]  = grant[i] && req[i] && out_free;
            pop_any = pop_any || pop[i];
        end
    end

    assign pop_tlast = src_tlast[winner];

    always_ff @(posedge axis_clk) begin
        if (rst) begin
            m_tvalid <= 1'b0;
        end else if (pop_any) begin
            m_tvalid <= 1'b1;
        end else if (m_tready) begin
            m_tvalid <= 1'b0;
        end
    end

    // Payload held while the sink stalls
    always_ff @(posedge axis_clk) begin
        if (pop_any) begin
            m_tdata <= src_tdata[winner];
            m_tkeep <= src_tkeep[winner];
            m_tlast <= pop_tlast;
            m_tid   <= winner;
        end
    end

endmodule : egress_arbiter

/* logic/ingress_port.sv */
`timescale 1ns/1ps

module ingress_port (
    input  logic                 axis_clk,
    input  logic                 rst,

    // Ingress AXI-Stream
    input  logic                 s_tvalid,
    output logic                 s_tready,
    input  smartnic_pkg::tdata_t s_tdata,
    input  smartnic_pkg::tkeep_t s_tkeep,
    input  logic                 s_tlast,
    input  smartnic_pkg::port_t  s_tdest,

    // Head beat, fanned out to every arbiter
    output smartnic_pkg::tdata_t head_tdata,
    output smartnic_pkg::tkeep_t head_tkeep,
    output logic                 head_tlast,
    output smartnic_pkg::req_t   req,
    input  smartnic_pkg::req_t   pop
);
    import smartnic_pkg::*;

    // ========================================
    // Skid buffer state
    // ========================================

    logic   head_valid;
    port_t  head_tdest;

    logic   skid_valid;
    tdata_t skid_tdata;
    tkeep_t skid_tkeep;
    logic   skid_tlast;
    port_t  skid_tdest;

    logic   accept;
    logic   advance;
    logic   head_load;

    // Only the requested egress ever pops us
    assign advance = |pop;

    // Head slot free this cycle
    assign head_load = !head_valid || advance;

    // Ready comes straight from a flop, never from egress
    assign s_tready = !skid_valid;
    assign accept   = s_tvalid && s_tready;

    // Valid flags
    always_ff @(posedge axis_clk) begin
        if (rst) begin
            head_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (head_load) begin
            if (skid_valid) begin
                head_valid <= 1'b1;
                skid_valid <= 1'b0;
            end else begin
                head_valid <= accept;
            end
        end else if (accept) begin
            // Head stalled, park the new beat
            skid_valid <= 1'b1;
        end
    end

    // Head payload
    always_ff @(posedge axis_clk) begin
        if (head_load) begin
            if (skid_valid) begin
                head_tdata <= skid_tdata;
                head_tkeep <= skid_tkeep;
                head_tlast <= skid_tlast;
                head_tdest <= skid_tdest;
            end else if (accept) begin
                head_tdata <= s_tdata;
                head_tkeep <= s_tkeep;
                head_tlast <= s_tlast;
                head_tdest <= s_tdest;
            end
        end
    end

    // Skid payload
    always_ff @(posedge axis_clk) begin
        if (accept && !head_load) begin
            skid_tdata <= s_tdata;
            skid_tkeep <= s_tkeep;
            skid_tlast <= s_tlast;
            skid_tdest <= s_tdest;
        end
    end

    // ========================================
    // Destination decode
    // ========================================

    // One-hot request toward the egress named by tdest
    always_comb begin
        req = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            req[i] = head_valid && (head_tdest == port_t'(i));
        end
    end

endmodule : ingress_port

/* logic/smartnic_pkg.sv */
package smartnic_pkg;

    // ========================================
    // Port geometry
    // ========================================

    // Ingress and egress share the same count
    localparam int NUM_PORTS = 4;

    // Index width for tid and tdest
    localparam int PORT_WID = 2;

    // ========================================
    // Beat widths
    // ========================================

    localparam int DATA_WID = 64;
    localparam int KEEP_WID = DATA_WID / 8;

    // ========================================
    // Types
    // ========================================

    // Port index, used by ingress tdest and egress tid/tdest
    typedef logic [PORT_WID-1:0] port_t;

    // One data beat and its byte enables
    typedef logic [DATA_WID-1:0] tdata_t;
    typedef logic [KEEP_WID-1:0] tkeep_t;

    // One bit per egress port
    // Doubles as the grant vector inside an arbiter
    typedef logic [NUM_PORTS-1:0] req_t;

    // Arbiter FSM
    typedef enum logic {
        ARB_IDLE,
        ARB_LOCKED
    } arb_state_e;

endpackage : smartnic_pkg

/* logic/smartnic_switch.sv */
`timescale 1ns/1ps

module smartnic_switch #(
    parameter int NUM_PORTS = smartnic_pkg::NUM_PORTS
) (
    input  logic                 axis_clk,
    input  logic                 rst,

    // Ingress, 0..1 CMAC and 2..3 H2C
    input  logic                 in_tvalid [NUM_PORTS],
    output logic                 in_tready [NUM_PORTS],
    input  smartnic_pkg::tdata_t in_tdata  [NUM_PORTS],
    input  smartnic_pkg::tkeep_t in_tkeep  [NUM_PORTS],
    input  logic                 in_tlast  [NUM_PORTS],
    input  smartnic_pkg::port_t  in_tdest  [NUM_PORTS],

    // Egress, 0..1 CMAC and 2..3 C2H
    output logic                 out_tvalid [NUM_PORTS],
    input  logic                 out_tready [NUM_PORTS],
    output smartnic_pkg::tdata_t out_tdata  [NUM_PORTS],
    output smartnic_pkg::tkeep_t out_tkeep  [NUM_PORTS],
    output logic                 out_tlast  [NUM_PORTS],
    output smartnic_pkg::port_t  out_tid    [NUM_PORTS],
    output smartnic_pkg::port_t  out_tdest  [NUM_PORTS]
);
    import smartnic_pkg::*;

    // ========================================
    // Crossbar wiring
    // ========================================

    // Indexed by source
    tdata_t head_tdata [NUM_PORTS];
    tkeep_t head_tkeep [NUM_PORTS];
    logic   head_tlast [NUM_PORTS];
    req_t   ing_req    [NUM_PORTS];
    req_t   ing_pop    [NUM_PORTS];

    // Indexed by egress, then source
    logic   arb_req [NUM_PORTS][NUM_PORTS];
    logic   arb_pop [NUM_PORTS][NUM_PORTS];

    // Transpose request and pop matrices
    generate
        for (genvar e = 0; e < NUM_PORTS; e++) begin : g_xpose_egr
            for (genvar s = 0; s < NUM_PORTS; s++) begin : g_xpose_src
                assign arb_req[e][s] = ing_req[s][e];
                assign ing_pop[s][e] = arb_pop[e][s];
            end
        end
    endgenerate

    // ========================================
    // Ingress slices
    // ========================================

    generate
        for (genvar s = 0; s < NUM_PORTS; s++) begin : g_ingress
            ingress_port u_ingress_port (
                .axis_clk   (axis_clk),
                .rst        (rst),
                .s_tvalid   (in_tvalid[s]),
                .s_tready   (in_tready[s]),
                .s_tdata    (in_tdata[s]),
                .s_tkeep    (in_tkeep[s]),
                .s_tlast    (in_tlast[s]),
                .s_tdest    (in_tdest[s]),
                .head_tdata (head_tdata[s]),
                .head_tkeep (head_tkeep[s]),
                .head_tlast (head_tlast[s]),
                .req        (ing_req[s]),
                .pop        (ing_pop[s])
            );
        end
    endgenerate

    // ========================================
    // Egress arbiters
    // ========================================

    generate
        for (genvar e = 0; e < NUM_PORTS; e++) begin : g_egress
            egress_arbiter #(
                .NUM_SRC (NUM_PORTS)
            ) u_egress_arbiter (
                .axis_clk  (axis_clk),
                .rst       (rst),
                .req       (arb_req[e]),
                .src_tdata (head_tdata),
                .src_tkeep (head_tkeep),
                .src_tlast (head_tlast),
                .pop       (arb_pop[e]),
                .m_tvalid  (out_tvalid[e]),
                .m_tready  (out_tready[e]),
                .m_tdata   (out_tdata[e]),
                .m_tkeep   (out_tkeep[e]),
                .m_tlast   (out_tlast[e]),
                .m_tid     (out_tid[e])
            );

            // Egress index is fixed per port
            assign out_tdest[e] = port_t'(e);
        end
    endgenerate

endmodule : smartnic_switch

/* run_sim.sh */
#!/bin/sh
# Build the switch testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir

verilator --binary --timing -j 0 \
    --top-module tb \
    --Mdir "$BUILD_DIR" \
    -f filelist.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$("./$BUILD_DIR/Vtb")
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The run only counts as passing when the testbench says so
if printf '%s\n' "$output" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi

echo "Testbench did not report a pass"
exit 1
